// File: hw/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  ////////////////////////////////////////////////////////////
  // sizes
  ////////////////////////////////////////////////////////////

  localparam int NUM_LINES  = 32;
  localparam int FB_DEPTH   = 8;
  localparam int INST_BYTES = 4;
  localparam int LINE_BYTES = 8;

  // derived widths
  localparam int LINE_OFS_W = $clog2(LINE_BYTES);
  localparam int IDX_W      = $clog2(NUM_LINES);
  localparam int TAG_W      = 8;
  localparam int FB_PTR_W   = $clog2(FB_DEPTH);

  ////////////////////////////////////////////////////////////
  // basic types
  ////////////////////////////////////////////////////////////

  typedef logic [63:0]         addr_t;
  typedef logic [63:0]         line_t;
  typedef logic [31:0]         inst_t;
  // zero tag means no transaction
  typedef logic [3:0]          mem_tag_t;
  typedef logic [IDX_W-1:0]    cache_idx_t;
  typedef logic [TAG_W-1:0]    cache_tag_t;
  typedef logic [FB_PTR_W-1:0] fb_ptr_t;
  typedef logic [FB_PTR_W:0]   fb_cnt_t;

  localparam addr_t   RESET_PC = '0;
  localparam fb_cnt_t FB_FULL  = fb_cnt_t'(FB_DEPTH);

  // store is part of the bus encoding, fetch only loads
  typedef enum logic [1:0] {
    BUS_NONE  = 2'h0,
    BUS_LOAD  = 2'h1,
    BUS_STORE = 2'h2
  } bus_cmd_e;

  typedef enum logic {
    MISS_IDLE = 1'b0,
    MISS_WAIT = 1'b1
  } miss_state_e;

  ////////////////////////////////////////////////////////////
  // bundles
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    bus_cmd_e command;
    addr_t    addr;
  } mem_req_t;

  typedef struct packed {
    mem_tag_t response;
    line_t    data;
    mem_tag_t tag;
  } mem_rsp_t;

  typedef struct packed {
    addr_t pc;
    inst_t inst;
  } fetch_entry_t;

  // address fields of the direct-mapped cache
  function automatic cache_idx_t addr_idx(addr_t a);
    return a[LINE_OFS_W +: IDX_W];
  endfunction

  function automatic cache_tag_t addr_tag(addr_t a);
    return a[LINE_OFS_W + IDX_W +: TAG_W];
  endfunction

endpackage

`default_nettype wire

// File: hw/icache_array.sv
`timescale 1ns/1ps
`default_nettype none

module icache_array (
  input  wire logic                  clock,
  input  wire logic                  arst_n,
  input  wire fetch_pkg::cache_idx_t rd_idx,
  input  wire fetch_pkg::cache_tag_t rd_tag,
  input  wire logic                  wr_en,
  input  wire fetch_pkg::cache_idx_t wr_idx,
  input  wire fetch_pkg::cache_tag_t wr_tag,
  input  wire fetch_pkg::line_t      wr_data,
  output fetch_pkg::line_t           rd_line,
  output logic                       rd_hit
);

  // storage
  fetch_pkg::line_t               data_mem [fetch_pkg::NUM_LINES];
  fetch_pkg::cache_tag_t          tag_mem  [fetch_pkg::NUM_LINES];
  logic [fetch_pkg::NUM_LINES-1:0] valid;

  ////////////////////////////////////////////////////////////
  // valid bits
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      valid <= '0;
    end else if (wr_en) begin
      valid[wr_idx] <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // data and tag fill
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (wr_en) begin
      data_mem[wr_idx] <= wr_data;
      tag_mem[wr_idx]  <= wr_tag;
    end
  end

  // combinational lookup
  assign rd_line = data_mem[rd_idx];
  assign rd_hit  = valid[rd_idx] && (tag_mem[rd_idx] == rd_tag);

endmodule

`default_nettype wire

// File: hw/icache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl (
  input  wire logic               clock,
  input  wire logic               arst_n,
  input  wire fetch_pkg::addr_t   fetch_addr,
  input  wire fetch_pkg::mem_rsp_t mem_rsp,
  output fetch_pkg::mem_req_t     mem_req,
  output logic                    hit,
  output fetch_pkg::line_t        line
);

  fetch_pkg::miss_state_e state, state_next;
  logic                   req_active, req_next;
  logic                   start_miss;
  logic                   wr_en;
  fetch_pkg::addr_t       miss_addr;
  fetch_pkg::mem_tag_t    wait_tag;

  icache_array u_icache_array (
    .clock   (clock),
    .arst_n  (arst_n),
    .rd_idx  (fetch_pkg::addr_idx(fetch_addr)),
    .rd_tag  (fetch_pkg::addr_tag(fetch_addr)),
    .wr_en   (wr_en),
    .wr_idx  (fetch_pkg::addr_idx(miss_addr)),
    .wr_tag  (fetch_pkg::addr_tag(miss_addr)),
    .wr_data (mem_rsp.data),
    .rd_line (line),
    .rd_hit  (hit)
  );

  ////////////////////////////////////////////////////////////
  // miss FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_next = state;
    req_next   = req_active;
    start_miss = 1'b0;
    wr_en      = 1'b0;
    case (state)
      fetch_pkg::MISS_IDLE: begin
        if (req_active) begin
          // nonzero response means accepted
          if (mem_rsp.response != '0) begin
            req_next   = 1'b0;
            state_next = fetch_pkg::MISS_WAIT;
          end
        end else if (!hit) begin
          start_miss = 1'b1;
          req_next   = 1'b1;
        end
      end
      fetch_pkg::MISS_WAIT: begin
        // fill in the tag match cycle so hit shows up next cycle
        if (mem_rsp.tag == wait_tag) begin
          wr_en      = 1'b1;
          state_next = fetch_pkg::MISS_IDLE;
        end
      end
      default: state_next = fetch_pkg::MISS_IDLE;
    endcase
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      state      <= fetch_pkg::MISS_IDLE;
      req_active <= 1'b0;
      wait_tag   <= '0;
    end else begin
      state      <= state_next;
      req_active <= req_next;
      if (req_active && (mem_rsp.response != '0)) begin
        wait_tag <= mem_rsp.response;
      end
    end
  end

  // line-aligned miss address
  always_ff @(posedge clock) begin
    if (start_miss) begin
      miss_addr <= {fetch_addr[63:fetch_pkg::LINE_OFS_W], {fetch_pkg::LINE_OFS_W{1'b0}}};
    end
  end

  // request held until accepted
  assign mem_req.command = req_active ? fetch_pkg::BUS_LOAD : fetch_pkg::BUS_NONE;
  assign mem_req.addr    = miss_addr;

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  // one load outstanding at a time
  a_no_load_in_wait : assert property (@(posedge clock) disable iff (!arst_n)
    (state == fetch_pkg::MISS_WAIT) |-> (mem_req.command != fetch_pkg::BUS_LOAD));

  // waiting always has a real tag to match
  a_wait_tag_valid : assert property (@(posedge clock) disable iff (!arst_n)
    (state == fetch_pkg::MISS_WAIT) |-> (wait_tag != '0));

endmodule

`default_nettype wire

// File: hw/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
  input  wire logic             clock,
  input  wire logic             arst_n,
  input  wire logic             hit,
  input  wire fetch_pkg::line_t line,
  input  wire logic             has_space,
  input  wire logic             redirect,
  input  wire fetch_pkg::addr_t redirect_pc,
  output fetch_pkg::addr_t      fetch_addr,
  output logic                  push,
  output fetch_pkg::fetch_entry_t entry
);

  fetch_pkg::addr_t pc;
  fetch_pkg::inst_t inst_sel;

  ////////////////////////////////////////////////////////////
  // program counter
  ////////////////////////////////////////////////////////////

  // redirect wins over sequential advance
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      pc <= fetch_pkg::RESET_PC;
    end else if (redirect) begin
      pc <= redirect_pc;
    end else if (push) begin
      pc <= pc + fetch_pkg::addr_t'(fetch_pkg::INST_BYTES);
    end
  end

  assign fetch_addr = pc;

  ////////////////////////////////////////////////////////////
  // instruction select and push
  ////////////////////////////////////////////////////////////

  // bit 2 picks the upper word of the line
  always_comb begin
    if (pc[2]) begin
      inst_sel = line[63:32];
    end else begin
      inst_sel = line[31:0];
    end
  end

  // stall on miss or full buffer, drop the cycle of a redirect
  assign push = hit && has_space && !redirect;

  assign entry.pc   = pc;
  assign entry.inst = inst_sel;

endmodule

`default_nettype wire

// File: hw/fetch_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_buffer (
  input  wire logic                    clock,
  input  wire logic                    arst_n,
  input  wire logic                    push,
  input  wire fetch_pkg::fetch_entry_t entry_in,
  input  wire logic                    take,
  input  wire logic                    flush,
  output logic                         inst_valid,
  output fetch_pkg::fetch_entry_t      entry_out,
  output logic                         has_space
);

  fetch_pkg::fetch_entry_t fifo_mem [fetch_pkg::FB_DEPTH];
  fetch_pkg::fb_ptr_t      head;
  fetch_pkg::fb_ptr_t      tail;
  fetch_pkg::fb_cnt_t      count;
  logic                    pop;

  // dispatch pull
  assign pop        = take && inst_valid;
  assign inst_valid = (count != '0);
  assign entry_out  = fifo_mem[head];

  // a pop this cycle frees a slot for the push
  assign has_space  = (count != fetch_pkg::FB_FULL) || pop;

  ////////////////////////////////////////////////////////////
  // pointers and count
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else if (flush) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (push) begin
        tail <= tail + fetch_pkg::fb_ptr_t'(1);
      end
      if (pop) begin
        head <= head + fetch_pkg::fb_ptr_t'(1);
      end
      case ({push, pop})
        2'b10:   count <= count + fetch_pkg::fb_cnt_t'(1);
        2'b01:   count <= count - fetch_pkg::fb_cnt_t'(1);
        default: count <= count;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // entry storage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (push && !flush) begin
      fifo_mem[tail] <= entry_in;
    end
  end

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  // fetch must respect has_space, a full queue only takes a push alongside a pop
  a_no_push_full : assert property (@(posedge clock) disable iff (!arst_n)
    (push && (count == fetch_pkg::FB_FULL)) |-> pop);

  a_count_range : assert property (@(posedge clock) disable iff (!arst_n)
    count <= fetch_pkg::FB_FULL);

endmodule

`default_nettype wire

// File: hw/fetch_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_frontend (
  input  wire logic                clock,
  input  wire logic                arst_n,
  input  wire fetch_pkg::mem_rsp_t mem_rsp,
  output fetch_pkg::mem_req_t      mem_req,
  input  wire logic                redirect,
  input  wire fetch_pkg::addr_t    redirect_pc,
  input  wire logic                take,
  output logic                     inst_valid,
  output fetch_pkg::fetch_entry_t  inst
);

  // cache to fetch
  fetch_pkg::addr_t        fetch_addr;
  logic                    hit;
  fetch_pkg::line_t        line;

  // fetch to buffer
  logic                    push;
  fetch_pkg::fetch_entry_t entry;
  logic                    has_space;

  ////////////////////////////////////////////////////////////
  // instruction cache and bus side
  ////////////////////////////////////////////////////////////

  icache_ctrl u_icache_ctrl (
    .clock      (clock),
    .arst_n     (arst_n),
    .fetch_addr (fetch_addr),
    .mem_rsp    (mem_rsp),
    .mem_req    (mem_req),
    .hit        (hit),
    .line       (line)
  );

  fetch_stage u_fetch_stage (
    .clock       (clock),
    .arst_n      (arst_n),
    .hit         (hit),
    .line        (line),
    .has_space   (has_space),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .fetch_addr  (fetch_addr),
    .push        (push),
    .entry       (entry)
  );

  ////////////////////////////////////////////////////////////
  // dispatch side
  ////////////////////////////////////////////////////////////

  // redirect empties the queue
  fetch_buffer u_fetch_buffer (
    .clock      (clock),
    .arst_n     (arst_n),
    .push       (push),
    .entry_in   (entry),
    .take       (take),
    .flush      (redirect),
    .inst_valid (inst_valid),
    .entry_out  (inst),
    .has_space  (has_space)
  );

endmodule

`default_nettype wire

// File: tests/mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module mem_model #(
  parameter logic [31:0] PATTERN = 32'hc0de_0000,
  parameter int          LATENCY = 6
) (
  input  wire logic                clock,
  input  wire logic                arst_n,
  input  wire fetch_pkg::mem_req_t mem_req,
  input  wire logic                reject,
  output fetch_pkg::mem_rsp_t      mem_rsp
);

  fetch_pkg::mem_tag_t next_tag;
  fetch_pkg::mem_tag_t reply_tag;
  fetch_pkg::addr_t    reply_addr;
  logic                pending;
  int                  wait_cnt;
  logic                accept;

  // memory contents follow the address
  function automatic fetch_pkg::inst_t word_at(fetch_pkg::addr_t a);
    return a[31:0] ^ PATTERN;
  endfunction

  assign accept           = (mem_req.command == fetch_pkg::BUS_LOAD) && !reject;
  assign mem_rsp.response = accept ? next_tag : '0;
  assign mem_rsp.tag      = (pending && (wait_cnt == 0)) ? reply_tag : '0;
  assign mem_rsp.data     = {word_at(reply_addr + fetch_pkg::addr_t'(4)), word_at(reply_addr)};

  ////////////////////////////////////////////////////////////
  // one reply slot, tags 1 to 15
  ////////////////////////////////////////////////////////////

  always @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      next_tag   <= 4'd1;
      reply_tag  <= '0;
      reply_addr <= '0;
      pending    <= 1'b0;
      wait_cnt   <= 0;
    end else begin
      if (pending) begin
        if (wait_cnt == 0) begin
          pending <= 1'b0;
        end else begin
          wait_cnt <= wait_cnt - 1;
        end
      end
      if (accept) begin
        pending    <= 1'b1;
        wait_cnt   <= LATENCY - 1;
        reply_tag  <= next_tag;
        reply_addr <= mem_req.addr;
        next_tag   <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
      end
    end
  end

endmodule

`default_nettype wire

// File: tests/tb_fetch_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_frontend;

  localparam logic [31:0] SEED        = 32'h0041_a3fc;
  localparam logic [31:0] PATTERN     = 32'hc0de_0000;
  localparam int          MEM_LATENCY = 6;
  localparam int          NUM_INSTS   = 600;
  localparam int          REDIR_EVERY = 150;
  // worst line refill with rejects, two words per line
  localparam int          LINE_CYCLES = 16;
  localparam int          MAX_CYCLES  = 100 + NUM_INSTS * LINE_CYCLES / 2;

  logic                    clock;
  logic                    arst_n;
  fetch_pkg::mem_req_t     mem_req;
  fetch_pkg::mem_rsp_t     mem_rsp;
  logic                    redirect;
  fetch_pkg::addr_t        redirect_pc;
  logic                    take;
  logic                    inst_valid;
  fetch_pkg::fetch_entry_t inst;
  logic                    reject;

  logic [31:0]         rnd_state;
  int                  errors;
  int                  checked;
  int                  loads;
  int                  redirects;
  int                  taken_since_redir;
  fetch_pkg::addr_t    exp_pc;
  logic                released;
  // lines that must still hit after a redirect
  logic                reuse_on;
  fetch_pkg::addr_t    reuse_lo;
  fetch_pkg::addr_t    reuse_hi;
  // bus tracking
  logic                bus_busy;
  fetch_pkg::mem_tag_t bus_tag;
  logic                rejected;
  fetch_pkg::addr_t    rejected_addr;

  fetch_frontend u_fetch_frontend (
    .clock       (clock),
    .arst_n      (arst_n),
    .mem_rsp     (mem_rsp),
    .mem_req     (mem_req),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .take        (take),
    .inst_valid  (inst_valid),
    .inst        (inst)
  );

  mem_model #(.PATTERN(PATTERN), .LATENCY(MEM_LATENCY)) u_mem_model (
    .clock   (clock),
    .arst_n  (arst_n),
    .mem_req (mem_req),
    .reject  (reject),
    .mem_rsp (mem_rsp)
  );

  function automatic logic [31:0] lcg_next(logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // expected instruction word at a pc
  function automatic fetch_pkg::inst_t ref_inst(fetch_pkg::addr_t pc);
    return pc[31:0] ^ PATTERN;
  endfunction

  ////////////////////////////////////////////////////////////
  // clock and stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // take about 70 %, reject about 20 %, redirect a few lines back
  task automatic drive_inputs();
    int back_lines;
    int half;
    rnd_state  = lcg_next(rnd_state);
    back_lines = 1 + int'(rnd_state[3:0]) % 10;
    half       = int'(rnd_state[4]);
    reject     = (rnd_state[23:16] < 8'd51);
    redirect   = 1'b0;
    if ((taken_since_redir >= REDIR_EVERY) && (rnd_state[9:8] == 2'b00)) begin
      redirect    = 1'b1;
      redirect_pc = (exp_pc & ~fetch_pkg::addr_t'(7)) - fetch_pkg::addr_t'(8 * back_lines)
                    + fetch_pkg::addr_t'(4 * half);
      take        = 1'b0;
    end else begin
      take = (rnd_state[31:24] < 8'd179);
    end
  endtask

  initial begin
    arst_n      = 1'b0;
    take        = 1'b0;
    reject      = 1'b0;
    redirect    = 1'b0;
    redirect_pc = '0;
    rnd_state   = SEED;
    repeat (4) @(posedge clock);
    #1 arst_n = 1'b1;
    forever begin
      @(posedge clock);
      #1;
      drive_inputs();
    end
  end

  ////////////////////////////////////////////////////////////
  // checks, sampled at the falling edge
  ////////////////////////////////////////////////////////////

  task automatic check_reset();
    if (mem_req.command !== fetch_pkg::BUS_NONE) begin
      errors++;
      $display("Fail at %0t ns: mem_req.command is %0d, expected %0d", $time,
               mem_req.command, fetch_pkg::BUS_NONE);
    end
    if (inst_valid !== 1'b0) begin
      errors++;
      $display("Fail at %0t ns: inst_valid is %b, expected 0", $time, inst_valid);
    end
  endtask

  task automatic check_bus();
    logic was_busy;
    was_busy = bus_busy;
    if (was_busy && (mem_rsp.tag == bus_tag)) begin
      bus_busy = 1'b0;
    end
    if (mem_req.command == fetch_pkg::BUS_LOAD) begin
      loads++;
      if (mem_req.addr[2:0] != 3'b000) begin
        errors++;
        $display("bus load address %h at %0t ns is not line aligned", mem_req.addr, $time);
      end
      if (was_busy) begin
        errors++;
        $display("bus load at %0t ns while tag %0d is still outstanding", $time, bus_tag);
      end
      if (rejected && (mem_req.addr != rejected_addr)) begin
        errors++;
        $display("Fail at %0t ns: mem_req.addr is %h, expected %h", $time,
                 mem_req.addr, rejected_addr);
      end
      if (reuse_on && (mem_req.addr >= reuse_lo) && (mem_req.addr < reuse_hi)) begin
        errors++;
        $display("line %h was loaded again at %0t ns though it should still be cached",
                 mem_req.addr, $time);
      end
      rejected      = (mem_rsp.response == '0);
      rejected_addr = mem_req.addr;
      if (!rejected) begin
        bus_busy = 1'b1;
        bus_tag  = mem_rsp.response;
      end
    end else if (rejected) begin
      errors++;
      rejected = 1'b0;
      $display("rejected request was dropped instead of repeated at %0t ns", $time);
    end
  endtask

  task automatic check_dispatch();
    if (redirect) begin
      redirects++;
      reuse_on          = 1'b1;
      reuse_lo          = redirect_pc & ~fetch_pkg::addr_t'(7);
      reuse_hi          = exp_pc & ~fetch_pkg::addr_t'(7);
      exp_pc            = redirect_pc;
      taken_since_redir = 0;
    end else if (take && inst_valid) begin
      if (inst.pc !== exp_pc) begin
        errors++;
        $display("Fail at %0t ns: inst.pc is %h, expected %h", $time, inst.pc, exp_pc);
      end
      if (inst.inst !== ref_inst(exp_pc)) begin
        errors++;
        $display("Fail at %0t ns: inst.inst is %h, expected %h", $time,
                 inst.inst, ref_inst(exp_pc));
      end
      exp_pc = exp_pc + fetch_pkg::addr_t'(fetch_pkg::INST_BYTES);
      checked++;
      taken_since_redir++;
    end
  endtask

  initial begin
    errors            = 0;
    checked           = 0;
    loads             = 0;
    redirects         = 0;
    taken_since_redir = 0;
    exp_pc            = fetch_pkg::RESET_PC;
    released          = 1'b0;
    reuse_on          = 1'b0;
    reuse_lo          = '0;
    reuse_hi          = '0;
    bus_busy          = 1'b0;
    bus_tag           = '0;
    rejected          = 1'b0;
    rejected_addr     = '0;
    forever begin
      @(negedge clock);
      // in reset and the first cycle after
      if (!released) begin
        check_reset();
        released = arst_n;
      end
      if (arst_n) begin
        check_bus();
        check_dispatch();
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // end of run and watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    do begin
      @(posedge clock);
    end while (checked < NUM_INSTS);
    $display("%0d instructions checked, %0d bus loads, %0d redirects, %0d errors",
             checked, loads, redirects, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    repeat (MAX_CYCLES) @(posedge clock);
    $display("run stopped after %0d cycles with %0d of %0d instructions checked, %0d errors",
             MAX_CYCLES, checked, NUM_INSTS, errors);
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
hw/fetch_pkg.sv
hw/icache_array.sv
hw/icache_ctrl.sv
hw/fetch_stage.sv
hw/fetch_buffer.sv
hw/fetch_frontend.sv
tests/mem_model.sv
tests/tb_fetch_frontend.sv

// File: run.sh
#!/bin/sh
# build and run the fetch front end testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 \
  --top-module tb_fetch_frontend -f src.f > build.log 2>&1 \
  && ./obj_dir/Vtb_fetch_frontend > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Test OK" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see build.log and sim.log"; exit 1; }
